// ==== design/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

`define XLEN   32
`define LANE_W 8
`define LANES  (`XLEN / `LANE_W)

// Base opcodes
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_CUSTOM0 7'b0001011

`define F7_ALT    7'b0100000 // SUB, SRA, SRAI
`define F7_MULDIV 7'b0000001 // M extension, not decoded
`define F3_JALR   3'b000

// Custom-0 groups
`define CUST3_DOTMAC 3'b000
`define CUST3_ADDSUB 3'b001
`define CUST3_MISC   3'b010
`define CUST3_RELU   3'b110

`define CUST7_DOT4_SS 7'b0000000
`define CUST7_DOT4_SU 7'b0000001
`define CUST7_DOT4_UU 7'b0000010
`define CUST7_ADD8    7'b0000000
`define CUST7_SUB8    7'b0000001
`define CUST7_ADDSAT8 7'b0000010
`define CUST7_SUBSAT8 7'b0000011
`define CUST7_MAX8    7'b0000000
`define CUST7_MIN8    7'b0000001
`define CUST7_RELU8   7'b0000000

`endif

// ==== design/ex_pkg.sv ====
`include "ex_defs.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0]   word_t;
    typedef logic [`LANE_W-1:0] lane_t;

    // Unit that owns alu_result
    typedef enum logic [1:0] {
        CLS_NONE = 2'd0,
        CLS_INT  = 2'd1,
        CLS_SIMD = 2'd2
    } op_class_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [3:0] {
        SIMD_DOT_SS, SIMD_DOT_SU, SIMD_DOT_UU,
        SIMD_ADD8, SIMD_SUB8, SIMD_ADDSAT8, SIMD_SUBSAT8,
        SIMD_MAX8, SIMD_MIN8, SIMD_RELU8
    } simd_op_t;

    // BR_BNONE is a branch funct3 that never takes but still has a target
    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU,
        BR_JAL, BR_JALR, BR_BNONE
    } br_cond_t;

endpackage

// ==== design/ex_int_alu.sv ====
`timescale 1ns/10ps

module ex_int_alu (
    input  ex_pkg::alu_op_t alu_op,
    input  ex_pkg::word_t   op_a,
    input  ex_pkg::word_t   op_b,
    output ex_pkg::word_t   int_result
);
    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = op_b[4:0];
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  int_result = op_a + op_b;
            ALU_SUB:  int_result = op_a - op_b;
            ALU_SLL:  int_result = op_a << shamt;
            ALU_SLT:  int_result = word_t'(lt_s);
            ALU_SLTU: int_result = word_t'(lt_u);
            ALU_XOR:  int_result = op_a ^ op_b;
            ALU_SRL:  int_result = op_a >> shamt;
            ALU_SRA:  int_result = $signed(op_a) >>> shamt; // Sign fill
            ALU_OR:   int_result = op_a | op_b;
            ALU_AND:  int_result = op_a & op_b;
            default:  int_result = '0;
        endcase
    end

endmodule

// ==== design/ex_simd_alu.sv ====
`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_simd_alu (
    input  ex_pkg::simd_op_t simd_op,
    input  ex_pkg::word_t    rs1_q,
    input  ex_pkg::word_t    rs2_q,
    output ex_pkg::word_t    simd_result
);
    import ex_pkg::*;

    word_t prod_w [`LANES];
    word_t lane_word;
    word_t dot_sum;
    logic  a_sgn;
    logic  b_sgn;
    logic  is_dot;

    // Clamp a sign-extended sum to the signed lane range
    function automatic lane_t sat_lane(input logic [`LANE_W:0] s);
        if (s[`LANE_W] != s[`LANE_W-1]) begin
            return {s[`LANE_W], {(`LANE_W-1){~s[`LANE_W]}}};
        end
        return s[`LANE_W-1:0];
    endfunction

    assign a_sgn  = (simd_op != SIMD_DOT_UU);
    assign b_sgn  = (simd_op == SIMD_DOT_SS);
    assign is_dot = (simd_op == SIMD_DOT_SS) || (simd_op == SIMD_DOT_SU) ||
                    (simd_op == SIMD_DOT_UU);

    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        lane_t              a;
        lane_t              b;
        lane_t              res;
        logic [`LANE_W:0]   sum;
        logic [`LANE_W:0]   dif;
        logic               a_lt_b;

        assign a      = rs1_q[i*`LANE_W +: `LANE_W];
        assign b      = rs2_q[i*`LANE_W +: `LANE_W];
        assign sum    = {a[`LANE_W-1], a} + {b[`LANE_W-1], b};
        assign dif    = {a[`LANE_W-1], a} - {b[`LANE_W-1], b};
        assign a_lt_b = $signed(a) < $signed(b);

        // 9-bit extension sets the signedness of each factor
        assign prod_w[i] = $signed({a_sgn & a[`LANE_W-1], a}) *
                           $signed({b_sgn & b[`LANE_W-1], b});

        always_comb begin
            case (simd_op)
                SIMD_ADD8:    res = sum[`LANE_W-1:0];
                SIMD_SUB8:    res = dif[`LANE_W-1:0];
                SIMD_ADDSAT8: res = sat_lane(sum);
                SIMD_SUBSAT8: res = sat_lane(dif);
                SIMD_MAX8:    res = a_lt_b ? b : a;
                SIMD_MIN8:    res = a_lt_b ? a : b;
                SIMD_RELU8:   res = a[`LANE_W-1] ? '0 : a;
                default:      res = '0;
            endcase
        end

        assign lane_word[i*`LANE_W +: `LANE_W] = res;
    end

    always_comb begin
        dot_sum = '0;
        for (int i = 0; i < `LANES; i++) begin
            dot_sum = dot_sum + prod_w[i];
        end
    end

    assign simd_result = is_dot ? dot_sum : lane_word;

endmodule

// ==== design/ex_branch_unit.sv ====
`timescale 1ns/10ps

module ex_branch_unit (
    input  ex_pkg::br_cond_t br_cond,
    input  ex_pkg::word_t    rs1_q,
    input  ex_pkg::word_t    rs2_q,
    input  ex_pkg::word_t    imm_q,
    input  ex_pkg::word_t    pc_q,
    output logic             br_taken,
    output ex_pkg::word_t    br_target
);
    import ex_pkg::*;

    word_t pc_tgt;
    word_t jalr_sum;
    logic  lt_s;
    logic  lt_u;

    assign pc_tgt   = pc_q + imm_q;
    assign jalr_sum = rs1_q + imm_q;
    assign lt_s     = $signed(rs1_q) < $signed(rs2_q);
    assign lt_u     = rs1_q < rs2_q;

    always_comb begin
        br_taken  = 1'b0;
        br_target = pc_tgt;
        case (br_cond)
            BR_EQ:    br_taken = (rs1_q == rs2_q);
            BR_NE:    br_taken = (rs1_q != rs2_q);
            BR_LT:    br_taken = lt_s;
            BR_GE:    br_taken = ~lt_s;
            BR_LTU:   br_taken = lt_u;
            BR_GEU:   br_taken = ~lt_u;
            BR_JAL:   br_taken = 1'b1;
            BR_JALR: begin
                br_taken  = 1'b1;
                br_target = jalr_sum & ~word_t'(1); // Clear bit 0
            end
            BR_BNONE: br_taken = 1'b0;
            default:  br_target = '0; // Not a control transfer
        endcase
    end

endmodule

// ==== design/ex_result_reg.sv ====
`timescale 1ns/10ps

module ex_result_reg (
    input  logic              clk,
    input  logic              rst,
    input  logic              op_valid,
    input  ex_pkg::op_class_t op_class,
    input  ex_pkg::word_t     int_result,
    input  ex_pkg::word_t     simd_result,
    input  logic              br_taken,
    input  ex_pkg::word_t     br_target,
    output logic              out_valid,
    output ex_pkg::word_t     alu_result,
    output logic              branch_taken,
    output ex_pkg::word_t     branch_target,
    output logic              custom_valid
);
    import ex_pkg::*;

    word_t result_d;

    always_comb begin
        case (op_class)
            CLS_INT:  result_d = int_result;
            CLS_SIMD: result_d = simd_result;
            default:  result_d = '0;
        endcase
    end

    // Flags drop whenever no result is presented
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid    <= 1'b0;
            branch_taken <= 1'b0;
            custom_valid <= 1'b0;
        end else begin
            out_valid    <= op_valid;
            branch_taken <= op_valid & br_taken;
            custom_valid <= op_valid & (op_class == CLS_SIMD);
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            alu_result    <= result_d;
            branch_target <= br_target;
        end
    end

endmodule

// ==== design/ex_decode.sv ====
`timescale 1ns/10ps
`include "ex_defs.svh"

module ex_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic [6:0]        opcode,
    input  logic [2:0]        funct3,
    input  logic [6:0]        funct7,
    input  ex_pkg::word_t     rs1_val,
    input  ex_pkg::word_t     rs2_val,
    input  ex_pkg::word_t     imm,
    input  ex_pkg::word_t     pc_in,
    output logic              op_valid,
    output ex_pkg::op_class_t op_class,
    output ex_pkg::alu_op_t   alu_op,
    output ex_pkg::simd_op_t  simd_op,
    output ex_pkg::br_cond_t  br_cond,
    output ex_pkg::word_t     op_a,
    output ex_pkg::word_t     op_b,
    output ex_pkg::word_t     rs1_q,
    output ex_pkg::word_t     rs2_q,
    output ex_pkg::word_t     imm_q,
    output ex_pkg::word_t     pc_q
);
    import ex_pkg::*;

    op_class_t cls_d;
    alu_op_t   alu_d;
    simd_op_t  simd_d;
    br_cond_t  br_d;
    word_t     a_d;
    word_t     b_d;

    function automatic alu_op_t alu_map(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        cls_d  = CLS_NONE;
        alu_d  = ALU_ADD;
        simd_d = SIMD_ADD8;
        br_d   = BR_NONE;
        a_d    = rs1_val;
        b_d    = imm;
        case (opcode)
            `OPC_OP: begin
                b_d = rs2_val;
                if (funct7 != `F7_MULDIV) begin
                    cls_d = CLS_INT;
                    alu_d = alu_map(funct3, funct7 == `F7_ALT);
                end
            end
            `OPC_OP_IMM: begin
                cls_d = CLS_INT;
                alu_d = alu_map(funct3, (funct3 == 3'b101) && (funct7 == `F7_ALT)); // SRAI only
            end
            `OPC_LOAD, `OPC_STORE: cls_d = CLS_INT; // Effective address
            `OPC_LUI: begin
                cls_d = CLS_INT;
                a_d   = '0;
            end
            `OPC_AUIPC: begin
                cls_d = CLS_INT;
                a_d   = pc_in;
            end
            `OPC_CUSTOM0: begin
                cls_d = CLS_SIMD;
                case ({funct3, funct7})
                    {`CUST3_DOTMAC, `CUST7_DOT4_SS}: simd_d = SIMD_DOT_SS;
                    {`CUST3_DOTMAC, `CUST7_DOT4_SU}: simd_d = SIMD_DOT_SU;
                    {`CUST3_DOTMAC, `CUST7_DOT4_UU}: simd_d = SIMD_DOT_UU;
                    {`CUST3_ADDSUB, `CUST7_ADD8}:    simd_d = SIMD_ADD8;
                    {`CUST3_ADDSUB, `CUST7_SUB8}:    simd_d = SIMD_SUB8;
                    {`CUST3_ADDSUB, `CUST7_ADDSAT8}: simd_d = SIMD_ADDSAT8;
                    {`CUST3_ADDSUB, `CUST7_SUBSAT8}: simd_d = SIMD_SUBSAT8;
                    {`CUST3_MISC, `CUST7_MAX8}:      simd_d = SIMD_MAX8;
                    {`CUST3_MISC, `CUST7_MIN8}:      simd_d = SIMD_MIN8;
                    {`CUST3_RELU, `CUST7_RELU8}:     simd_d = SIMD_RELU8;
                    default:                         cls_d  = CLS_NONE;
                endcase
            end
            `OPC_BRANCH: begin
                case (funct3)
                    3'b000:  br_d = BR_EQ;
                    3'b001:  br_d = BR_NE;
                    3'b100:  br_d = BR_LT;
                    3'b101:  br_d = BR_GE;
                    3'b110:  br_d = BR_LTU;
                    3'b111:  br_d = BR_GEU;
                    default: br_d = BR_BNONE; // 010/011
                endcase
            end
            `OPC_JAL: br_d = BR_JAL;
            `OPC_JALR: begin
                if (funct3 == `F3_JALR) begin
                    br_d = BR_JALR;
                end
            end
            default: cls_d = CLS_NONE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_class <= cls_d;
            alu_op   <= alu_d;
            simd_op  <= simd_d;
            br_cond  <= br_d;
            op_a     <= a_d;
            op_b     <= b_d;
            rs1_q    <= rs1_val;
            rs2_q    <= rs2_val;
            imm_q    <= imm;
            pc_q     <= pc_in;
        end
    end

endmodule

// ==== design/ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage (
    input  logic          clk,
    input  logic          rst,
    input  logic          in_valid,
    input  logic [6:0]    opcode,
    input  logic [2:0]    funct3,
    input  logic [6:0]    funct7,
    input  ex_pkg::word_t rs1_val,
    input  ex_pkg::word_t rs2_val,
    input  ex_pkg::word_t imm,
    input  ex_pkg::word_t pc_in,
    output logic          out_valid,
    output ex_pkg::word_t alu_result,
    output logic          branch_taken,
    output ex_pkg::word_t branch_target,
    output logic          custom_valid
);
    import ex_pkg::*;

    logic      op_valid;
    op_class_t op_class;
    alu_op_t   alu_op;
    simd_op_t  simd_op;
    br_cond_t  br_cond;
    word_t     op_a;
    word_t     op_b;
    word_t     rs1_q;
    word_t     rs2_q;
    word_t     imm_q;
    word_t     pc_q;
    word_t     int_result;
    word_t     simd_result;
    logic      br_taken;
    word_t     br_target;

    ex_decode u_decode (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .opcode   (opcode),
        .funct3   (funct3),
        .funct7   (funct7),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .imm      (imm),
        .pc_in    (pc_in),
        .op_valid (op_valid),
        .op_class (op_class),
        .alu_op   (alu_op),
        .simd_op  (simd_op),
        .br_cond  (br_cond),
        .op_a     (op_a),
        .op_b     (op_b),
        .rs1_q    (rs1_q),
        .rs2_q    (rs2_q),
        .imm_q    (imm_q),
        .pc_q     (pc_q)
    );

    ex_int_alu u_int_alu (
        .alu_op     (alu_op),
        .op_a       (op_a),
        .op_b       (op_b),
        .int_result (int_result)
    );

    ex_simd_alu u_simd_alu (
        .simd_op     (simd_op),
        .rs1_q       (rs1_q),
        .rs2_q       (rs2_q),
        .simd_result (simd_result)
    );

    ex_branch_unit u_branch_unit (
        .br_cond   (br_cond),
        .rs1_q     (rs1_q),
        .rs2_q     (rs2_q),
        .imm_q     (imm_q),
        .pc_q      (pc_q),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    ex_result_reg u_result_reg (
        .clk           (clk),
        .rst           (rst),
        .op_valid      (op_valid),
        .op_class      (op_class),
        .int_result    (int_result),
        .simd_result   (simd_result),
        .br_taken      (br_taken),
        .br_target     (br_target),
        .out_valid     (out_valid),
        .alu_result    (alu_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .custom_valid  (custom_valid)
    );

endmodule

// ==== dv/tb_ex_ref.svh ====
`ifndef TB_EX_REF_SVH
`define TB_EX_REF_SVH

typedef struct packed {
    logic [31:0] result;
    logic        taken;
    logic [31:0] target;
    logic        cv;
    logic [31:0] due;
} exp_t;

// Galois form, taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic word_t rand_bits(input int n);
    word_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
endfunction

function automatic word_t rand_simm(input int n);
    word_t v;
    v = rand_bits(n);
    if (v[n-1]) begin
        v = v | ~((32'd1 << n) - 32'd1); // Sign extend
    end
    return v;
endfunction

// Index order is the one simd_ref uses
function automatic logic [9:0] cust_pair(input int k);
    case (k)
        0:       return {`CUST3_DOTMAC, `CUST7_DOT4_SS};
        1:       return {`CUST3_DOTMAC, `CUST7_DOT4_SU};
        2:       return {`CUST3_DOTMAC, `CUST7_DOT4_UU};
        3:       return {`CUST3_ADDSUB, `CUST7_ADD8};
        4:       return {`CUST3_ADDSUB, `CUST7_SUB8};
        5:       return {`CUST3_ADDSUB, `CUST7_ADDSAT8};
        6:       return {`CUST3_ADDSUB, `CUST7_SUBSAT8};
        7:       return {`CUST3_MISC, `CUST7_MAX8};
        8:       return {`CUST3_MISC, `CUST7_MIN8};
        default: return {`CUST3_RELU, `CUST7_RELU8};
    endcase
endfunction

function automatic int cust_index(input logic [2:0] f3, input logic [6:0] f7);
    int k;
    k = -1;
    for (int j = 0; j < 10; j++) begin
        if (cust_pair(j) == {f3, f7}) begin
            k = j;
        end
    end
    return k;
endfunction

function automatic int clamp8(input int v);
    if (v > 127) begin
        return 127;
    end
    if (v < -128) begin
        return -128;
    end
    return v;
endfunction

function automatic word_t int_ref(input logic [2:0] f3, input logic alt,
                                  input word_t x, input word_t y);
    word_t fill;
    fill = x[31] ? ~(32'hFFFF_FFFF >> y[4:0]) : 32'd0;
    case (f3)
        3'b000:  return alt ? x - y : x + y;
        3'b001:  return x << y[4:0];
        3'b010:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
        3'b011:  return (x < y) ? 32'd1 : 32'd0;
        3'b100:  return x ^ y;
        3'b101:  return alt ? ((x >> y[4:0]) | fill) : (x >> y[4:0]);
        3'b110:  return x | y;
        default: return x & y;
    endcase
endfunction

function automatic word_t simd_ref(input int k, input word_t x, input word_t y);
    int    a;
    int    b;
    int    ua;
    int    ub;
    int    v;
    int    acc;
    word_t r;
    r   = '0;
    acc = 0;
    for (int i = 0; i < `LANES; i++) begin
        a  = $signed(x[i*`LANE_W +: `LANE_W]);
        b  = $signed(y[i*`LANE_W +: `LANE_W]);
        ua = {24'd0, x[i*`LANE_W +: `LANE_W]};
        ub = {24'd0, y[i*`LANE_W +: `LANE_W]};
        v  = 0;
        case (k)
            0:       acc = acc + a * b;
            1:       acc = acc + a * ub; // rs1 signed, rs2 unsigned
            2:       acc = acc + ua * ub;
            3:       v = a + b;
            4:       v = a - b;
            5:       v = clamp8(a + b);
            6:       v = clamp8(a - b);
            7:       v = (a > b) ? a : b;
            8:       v = (a < b) ? a : b;
            default: v = (a < 0) ? 0 : a;
        endcase
        r[i*`LANE_W +: `LANE_W] = v[7:0];
    end
    return (k < 3) ? word_t'(acc) : r;
endfunction

function automatic exp_t ex_ref(input logic [6:0] opc, input logic [2:0] f3,
                                input logic [6:0] f7, input word_t a, input word_t b,
                                input word_t im, input word_t pc);
    exp_t e;
    int   k;
    e = '0;
    k = cust_index(f3, f7);
    case (opc)
        `OPC_OP: begin
            if (f7 != `F7_MULDIV) begin
                e.result = int_ref(f3, f7 == `F7_ALT, a, b);
            end
        end
        `OPC_OP_IMM:           e.result = int_ref(f3, (f3 == 3'b101) && (f7 == `F7_ALT), a, im);
        `OPC_LOAD, `OPC_STORE: e.result = a + im;
        `OPC_LUI:              e.result = im;
        `OPC_AUIPC:            e.result = pc + im;
        `OPC_BRANCH: begin
            e.target = pc + im;
            case (f3)
                3'b000:  e.taken = (a == b);
                3'b001:  e.taken = (a != b);
                3'b100:  e.taken = $signed(a) < $signed(b);
                3'b101:  e.taken = $signed(a) >= $signed(b);
                3'b110:  e.taken = a < b;
                3'b111:  e.taken = a >= b;
                default: e.taken = 1'b0;
            endcase
        end
        `OPC_JAL: begin
            e.taken  = 1'b1;
            e.target = pc + im;
        end
        `OPC_JALR: begin
            if (f3 == 3'b000) begin
                e.taken  = 1'b1;
                e.target = (a + im) & 32'hFFFF_FFFE;
            end
        end
        `OPC_CUSTOM0: begin
            if (k >= 0) begin
                e.result = simd_ref(k, a, b);
                e.cv     = 1'b1;
            end
        end
        default: e.result = '0;
    endcase
    return e;
endfunction

task automatic compare_field(input string what, input word_t got, input word_t want);
    if (got !== want) begin
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, want);
        $display("ERRORS FOUND");
        $fatal(1);
    end
endtask

`endif

// ==== dv/tb_ex_stage.sv ====
`timescale 1ns/10ps
`include "ex_defs.svh"

module tb_ex_stage;
    import ex_pkg::*;

    localparam int RST_CYC     = 4;
    localparam int N_INT       = 80;
    localparam int N_MEXT      = 8;
    localparam int N_MEM       = 24;
    localparam int N_BR        = 32;
    localparam int N_JUMP      = 12;
    localparam int N_SIMD      = 100;
    localparam int N_CORNER    = 10;
    localparam int N_BADCUST   = 20;
    localparam int N_INSTR     = 4 + N_INT + N_MEXT + N_MEM + N_BR + N_JUMP + N_SIMD +
                                 N_CORNER + N_BADCUST;
    localparam int IDLE_CYC    = 32; // Gaps between groups and final drain
    localparam int TIMEOUT_CYC = RST_CYC + IDLE_CYC + N_INSTR + 20;

    logic        clk;
    logic        rst;
    logic        in_valid;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       imm;
    word_t       pc_in;
    logic        out_valid;
    word_t       alu_result;
    logic        branch_taken;
    word_t       branch_target;
    logic        custom_valid;

    logic [31:0] lfsr_state = 32'd15913;
    int          cyc = 0;
    bit          have_last = 1'b0;
    word_t       last_result;
    word_t       last_target;

    `include "tb_ex_ref.svh"

    exp_t exp_q [$];

    ex_stage dut0 (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .opcode        (opcode),
        .funct3        (funct3),
        .funct7        (funct7),
        .rs1_val       (rs1_val),
        .rs2_val       (rs2_val),
        .imm           (imm),
        .pc_in         (pc_in),
        .out_valid     (out_valid),
        .alu_result    (alu_result),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .custom_valid  (custom_valid)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            $display("Timeout: test still running after %0d cycles", cyc);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    task automatic send_instr(input logic [6:0] opc, input logic [2:0] f3,
                              input logic [6:0] f7, input word_t a, input word_t b,
                              input word_t im, input word_t pc);
        exp_t e;
        @(negedge clk);
        in_valid = 1'b1;
        opcode   = opc;
        funct3   = f3;
        funct7   = f7;
        rs1_val  = a;
        rs2_val  = b;
        imm      = im;
        pc_in    = pc;
        e        = ex_ref(opc, f3, f7, a, b, im, pc);
        e.due    = cyc + 2; // Sampled at the next edge, result two edges later
        exp_q.push_back(e);
    endtask

    task automatic send_custom(input int k, input word_t a, input word_t b);
        logic [9:0] pair;
        pair = cust_pair(k);
        send_instr(`OPC_CUSTOM0, pair[9:7], pair[6:0], a, b, '0, '0);
    endtask

    task automatic run_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    always @(posedge clk) begin : compare_proc
        exp_t e;
        if (!rst) begin
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected output at %0t with no instruction in flight", $time);
                    $display("ERRORS FOUND");
                    $fatal(1);
                end else begin
                    e = exp_q.pop_front();
                    compare_field("out_valid cycle", word_t'(cyc), e.due);
                    compare_field("alu_result", alu_result, e.result);
                    compare_field("branch_taken", word_t'(branch_taken), word_t'(e.taken));
                    compare_field("branch_target", branch_target, e.target);
                    compare_field("custom_valid", word_t'(custom_valid), word_t'(e.cv));
                    last_result = alu_result;
                    last_target = branch_target;
                    have_last   = 1'b1;
                end
            end else begin
                compare_field("idle branch_taken", word_t'(branch_taken), '0);
                compare_field("idle custom_valid", word_t'(custom_valid), '0);
                if (have_last) begin
                    compare_field("held alu_result", alu_result, last_result);
                    compare_field("held branch_target", branch_target, last_target);
                end
            end
        end
    end

    initial begin
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      im;
        word_t      pc;
        clk      = 1'b0;
        rst      = 1'b1;
        in_valid = 1'b0;
        opcode   = '0;
        funct3   = '0;
        funct7   = '0;
        rs1_val  = '0;
        rs2_val  = '0;
        imm      = '0;
        pc_in    = '0;
        repeat (RST_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        run_idle(4); // Quiet after reset

        send_instr(`OPC_OP, 3'b000, 7'b0, 32'd5, 32'd7, '0, '0);
        send_instr(`OPC_OP, 3'b000, `F7_ALT, 32'd5, 32'd7, '0, '0); // SUB
        send_instr(`OPC_OP, 3'b101, `F7_ALT, 32'h8000_00F0, 32'd4, '0, '0); // SRA
        send_instr(`OPC_OP_IMM, 3'b101, `F7_ALT, 32'h8000_00F0, 32'h0000_0403,
                   32'h0000_0403, '0); // SRAI by 3
        run_idle(3);

        for (int i = 0; i < N_INT; i++) begin
            f3 = 3'(rand_bits(3));
            a  = rand_bits(32);
            b  = rand_bits(32);
            if (rand_bits(1) == 1) begin
                f7 = 7'b0;
                if ((f3 == 3'b000 || f3 == 3'b101) && rand_bits(1) == 1) begin
                    f7 = `F7_ALT;
                end
                send_instr(`OPC_OP, f3, f7, a, b, '0, '0);
            end else begin
                im = rand_simm(12);
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    im = {27'd0, im[4:0]}; // Shift amount only
                    if (f3 == 3'b101 && rand_bits(1) == 1) begin
                        im[10] = 1'b1; // SRAI
                    end
                end
                send_instr(`OPC_OP_IMM, f3, im[11:5], a, im, im, '0);
            end
        end
        run_idle(2);

        for (int i = 0; i < N_MEXT; i++) begin
            f3 = 3'(rand_bits(3));
            a  = rand_bits(32);
            b  = rand_bits(32);
            send_instr(`OPC_OP, f3, `F7_MULDIV, a, b, '0, '0);
        end
        run_idle(2);

        for (int i = 0; i < N_MEM; i++) begin
            case (rand_bits(2))
                0:       opc = `OPC_LOAD;
                1:       opc = `OPC_STORE;
                2:       opc = `OPC_LUI;
                default: opc = `OPC_AUIPC;
            endcase
            f3 = 3'(rand_bits(3));
            a  = rand_bits(32);
            b  = rand_bits(32);
            pc = rand_bits(30) << 2;
            im = (opc == `OPC_LUI || opc == `OPC_AUIPC) ? rand_bits(20) << 12 : rand_simm(12);
            send_instr(opc, f3, 7'b0, a, b, im, pc);
        end
        run_idle(2);

        for (int i = 0; i < N_BR; i++) begin
            f3 = 3'(i % 8);
            a  = rand_bits(32);
            b  = (i < 8) ? a : rand_bits(32); // First pass has equal operands
            im = rand_simm(13) & 32'hFFFF_FFFE;
            pc = rand_bits(30) << 2;
            send_instr(`OPC_BRANCH, f3, 7'b0, a, b, im, pc);
        end
        run_idle(2);

        for (int i = 0; i < N_JUMP; i++) begin
            pc = rand_bits(30) << 2;
            a  = rand_bits(32);
            im = rand_simm(12);
            if (i % 3 == 0) begin
                send_instr(`OPC_JAL, 3'(rand_bits(3)), 7'b0, a, '0, rand_simm(21) & ~32'd1, pc);
            end else if (i % 3 == 1) begin
                a[0] = ~im[0]; // Odd sum so bit 0 must clear
                send_instr(`OPC_JALR, 3'b000, 7'b0, a, '0, im, pc);
            end else begin
                f3 = 3'(rand_bits(3));
                if (f3 == 3'b000) begin
                    f3 = 3'b010;
                end
                send_instr(`OPC_JALR, f3, 7'b0, a, '0, im, pc);
            end
        end
        run_idle(2);

        for (int i = 0; i < N_SIMD; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            send_custom(int'(rand_bits(4)) % 10, a, b);
        end
        run_idle(2);

        send_custom(5, 32'h7F7F_8080, 32'h017F_FF80); // ADDSAT8 both rails
        send_custom(6, 32'h7F80_7F80, 32'hFF01_807F); // SUBSAT8 both rails
        send_custom(7, 32'h7F80_01FF, 32'h807F_FF01);
        send_custom(8, 32'h7F80_01FF, 32'h807F_FF01);
        send_custom(9, 32'h8000_7F80, 32'h0000_0000);
        send_custom(0, 32'h8080_8080, 32'h8080_8080);
        send_custom(1, 32'h8080_8080, 32'hFFFF_FFFF);
        send_custom(2, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        send_custom(0, 32'hFFFF_FFFF, 32'h8080_8080);
        send_custom(1, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
        run_idle(2);

        for (int i = 0; i < N_BADCUST; i++) begin
            do begin
                f3 = 3'(rand_bits(3));
                f7 = 7'(rand_bits(3));
            end while (cust_index(f3, f7) >= 0);
            a = rand_bits(32);
            b = rand_bits(32);
            send_instr(`OPC_CUSTOM0, f3, f7, a, b, '0, '0);
        end
        run_idle(4); // Drain the pipeline

        if (exp_q.size() != 0) begin
            $display("Missing outputs: %0d instructions gave no out_valid", exp_q.size());
            $display("ERRORS FOUND");
            $fatal(1);
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+design
+incdir+dv
design/ex_pkg.sv
design/ex_int_alu.sv
design/ex_simd_alu.sv
design/ex_branch_unit.sv
design/ex_result_reg.sv
design/ex_decode.sv
design/ex_stage.sv
dv/tb_ex_stage.sv

// ==== Makefile ====
TOP = tb_ex_stage

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f sources.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
